// File: design/rvv_config.svh
`ifndef RVV_CONFIG_SVH
`define RVV_CONFIG_SVH

// Intake and decode widths
`define ISSUE_LANE      4
`define NUM_DE_INST     2

// Command queue sizing, depth must be a power of two
`define CQ_DEPTH        8
`define CQ_PTR_W        3
`define CQ_CNT_W        4

// Vector register geometry
`define VLEN            128
`define SEW             8
`define VELEM_NUM       (`VLEN / `SEW)
`define NUM_VREG        32
`define VREG_IDX_W      5

// Scalar operand width from the core
`define XLEN            32

`endif

// File: design/rvv_data_pkg.sv
`include "rvv_config.svh"

package rvv_data_pkg;

    // One element at the fixed SEW
    typedef logic [`SEW-1:0] elem_t;

    // Whole vector register, LMUL of one
    typedef logic [`VLEN-1:0] vreg_t;

    // Retire report per lane
    typedef struct packed {
        logic [`VREG_IDX_W-1:0] vd;
        vreg_t                  data;
    } rt_result_t;

endpackage

// File: design/rvv_inst_pkg.sv
`include "rvv_config.svh"

package rvv_inst_pkg;

    // Supported integer ALU ops
    typedef enum logic [1:0] {
        VOP_ADD_VV  = 2'd0,
        VOP_ADD_VX  = 2'd1,
        VOP_SUB_VV  = 2'd2,
        VOP_RSUB_VX = 2'd3
    } vop_e;

    typedef logic [`VREG_IDX_W-1:0] vreg_idx_t;
    typedef logic [`XLEN-1:0]       xdata_t;

    // Command as sent by the scalar core
    typedef struct packed {
        xdata_t    inst_pc;
        vop_e      op;
        vreg_idx_t vd;
        vreg_idx_t vs1;
        vreg_idx_t vs2;
        xdata_t    rs1_data;
    } rvv_cmd_t;

    // Decoded uop, bypass flags only valid in lane 1
    typedef struct packed {
        vop_e                op;
        vreg_idx_t           vd;
        vreg_idx_t           vs1;
        vreg_idx_t           vs2;
        rvv_data_pkg::elem_t scalar;
        logic                byp_vs1;
        logic                byp_vs2;
    } rvv_uop_t;

endpackage

// File: design/rvv_cmd_queue.sv
`include "rvv_config.svh"

module rvv_cmd_queue (
    input  logic                                     clk,
    input  logic                                     rst_n,

    input  logic                [`ISSUE_LANE-1:0]    insts_valid,
    input  rvv_inst_pkg::rvv_cmd_t [`ISSUE_LANE-1:0] insts,
    output logic                [`ISSUE_LANE-1:0]    insts_ready,

    output logic                [`NUM_DE_INST-1:0]   head_valid,
    output rvv_inst_pkg::rvv_cmd_t [`NUM_DE_INST-1:0] head
);

    rvv_inst_pkg::rvv_cmd_t mem [`CQ_DEPTH];

    logic [`CQ_PTR_W-1:0] wr_ptr;
    logic [`CQ_PTR_W-1:0] rd_ptr;
    logic [`CQ_CNT_W-1:0] count;
    logic [`CQ_CNT_W-1:0] free_cnt;

    logic [`ISSUE_LANE-1:0]  push;
    logic [`CQ_CNT_W-1:0]    push_num;
    logic [`CQ_PTR_W-1:0]    wr_slot [`ISSUE_LANE];
    logic [`CQ_CNT_W-1:0]    pop_num;

    assign free_cnt = `CQ_CNT_W'(`CQ_DEPTH) - count;

    // Thermometer ready, lane k needs k+1 free slots
    always_comb begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            insts_ready[k] = free_cnt > `CQ_CNT_W'(k);
        end
    end

    // Accepted lanes packed into consecutive slots
    always_comb begin
        push     = insts_valid & insts_ready;
        push_num = '0;
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            wr_slot[k] = wr_ptr + push_num[`CQ_PTR_W-1:0];
            if (push[k]) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    // Head view, oldest entry in lane 0
    always_comb begin
        pop_num = '0;
        for (int j = 0; j < `NUM_DE_INST; j++) begin
            head_valid[j] = count > `CQ_CNT_W'(j);
            head[j]       = mem[rd_ptr + `CQ_PTR_W'(j)];
            // Decode never stalls so every visible head is popped
            if (head_valid[j]) begin
                pop_num = pop_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            if (push[k]) begin
                mem[wr_slot[k]] <= insts[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own since depth is a power of two
            wr_ptr <= wr_ptr + push_num[`CQ_PTR_W-1:0];
            rd_ptr <= rd_ptr + pop_num[`CQ_PTR_W-1:0];
            count  <= count + push_num - pop_num;
        end
    end

endmodule

// File: design/rvv_decode.sv
`include "rvv_config.svh"

module rvv_decode (
    input  logic                                      clk,
    input  logic                                      rst_n,

    input  logic                [`NUM_DE_INST-1:0]    head_valid,
    input  rvv_inst_pkg::rvv_cmd_t [`NUM_DE_INST-1:0] head,

    output logic                [`NUM_DE_INST-1:0]    uop_valid,
    output rvv_inst_pkg::rvv_uop_t [`NUM_DE_INST-1:0] uop
);

    rvv_inst_pkg::rvv_uop_t [`NUM_DE_INST-1:0] uop_nxt;

    logic lane1_reads_vs1;

    always_comb begin
        for (int j = 0; j < `NUM_DE_INST; j++) begin
            uop_nxt[j].op      = head[j].op;
            uop_nxt[j].vd      = head[j].vd;
            uop_nxt[j].vs1     = head[j].vs1;
            uop_nxt[j].vs2     = head[j].vs2;
            // Only the low element bits of rs1 matter at this SEW
            uop_nxt[j].scalar  = head[j].rs1_data[`SEW-1:0];
            uop_nxt[j].byp_vs1 = 1'b0;
            uop_nxt[j].byp_vs2 = 1'b0;
        end

        // vx ops take the scalar instead of vs1
        lane1_reads_vs1 = (head[1].op == rvv_inst_pkg::VOP_ADD_VV) ||
                          (head[1].op == rvv_inst_pkg::VOP_SUB_VV);

        // Same-cycle RAW on lane 0's destination
        if (head_valid[0] && head_valid[1]) begin
            uop_nxt[1].byp_vs1 = lane1_reads_vs1 && (head[1].vs1 == head[0].vd);
            uop_nxt[1].byp_vs2 = head[1].vs2 == head[0].vd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= '0;
        end else begin
            uop_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `NUM_DE_INST; j++) begin
            if (head_valid[j]) begin
                uop[j] <= uop_nxt[j];
            end
        end
    end

endmodule

// File: design/rvv_vexec.sv
`include "rvv_config.svh"

module rvv_vexec (
    input  logic                                        clk,
    input  logic                                        rst_n,

    input  logic                  [`NUM_DE_INST-1:0]    uop_valid,
    input  rvv_inst_pkg::rvv_uop_t   [`NUM_DE_INST-1:0] uop,

    output logic                  [`NUM_DE_INST-1:0]    rt_valid,
    output rvv_data_pkg::rt_result_t [`NUM_DE_INST-1:0] rt
);

    rvv_data_pkg::vreg_t vrf [`NUM_VREG];

    rvv_data_pkg::vreg_t src1 [`NUM_DE_INST];
    rvv_data_pkg::vreg_t src2 [`NUM_DE_INST];
    rvv_data_pkg::vreg_t res  [`NUM_DE_INST];
    logic                is_vx [`NUM_DE_INST];

    // Element-wise op, a is vs1 or the scalar and b is vs2
    function automatic rvv_data_pkg::vreg_t vec_alu(
        input rvv_inst_pkg::vop_e  op,
        input rvv_data_pkg::vreg_t a,
        input rvv_data_pkg::vreg_t b
    );
        rvv_data_pkg::vreg_t r;
        rvv_data_pkg::elem_t ea;
        rvv_data_pkg::elem_t eb;
        r = '0;
        for (int e = 0; e < `VELEM_NUM; e++) begin
            ea = a[e*`SEW +: `SEW];
            eb = b[e*`SEW +: `SEW];
            // Results wrap at the element width
            case (op)
                rvv_inst_pkg::VOP_ADD_VV,
                rvv_inst_pkg::VOP_ADD_VX:  r[e*`SEW +: `SEW] = eb + ea;
                rvv_inst_pkg::VOP_SUB_VV:  r[e*`SEW +: `SEW] = eb - ea;
                rvv_inst_pkg::VOP_RSUB_VX: r[e*`SEW +: `SEW] = ea - eb;
                default:                   r[e*`SEW +: `SEW] = '0;
            endcase
        end
        return r;
    endfunction

    // Operand select and compute, lane 0 resolved first for the bypass
    always_comb begin
        for (int j = 0; j < `NUM_DE_INST; j++) begin
            is_vx[j] = (uop[j].op == rvv_inst_pkg::VOP_ADD_VX) ||
                       (uop[j].op == rvv_inst_pkg::VOP_RSUB_VX);

            if (is_vx[j]) begin
                src1[j] = {`VELEM_NUM{uop[j].scalar}};
            end else begin
                src1[j] = vrf[uop[j].vs1];
            end
            src2[j] = vrf[uop[j].vs2];

            if (j > 0) begin
                if (uop[j].byp_vs1) begin
                    src1[j] = res[0];
                end
                if (uop[j].byp_vs2) begin
                    src2[j] = res[0];
                end
            end

            res[j] = vec_alu(uop[j].op, src1[j], src2[j]);
        end
    end

    // Register file, reset image puts k in every element of vk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `NUM_VREG; k++) begin
                vrf[k] <= {`VELEM_NUM{rvv_data_pkg::elem_t'(k)}};
            end
        end else begin
            // Ascending order so lane 1 wins on a shared vd
            for (int j = 0; j < `NUM_DE_INST; j++) begin
                if (uop_valid[j]) begin
                    vrf[uop[j].vd] <= res[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_valid <= '0;
        end else begin
            rt_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `NUM_DE_INST; j++) begin
            if (uop_valid[j]) begin
                rt[j].vd   <= uop[j].vd;
                rt[j].data <= res[j];
            end
        end
    end

endmodule

// File: design/rvv_backend.sv
`include "rvv_config.svh"

module rvv_backend (
    input  logic                                        clk,
    input  logic                                        rst_n,

    // Command intake from the scalar core
    input  logic                  [`ISSUE_LANE-1:0]     insts_valid,
    input  rvv_inst_pkg::rvv_cmd_t   [`ISSUE_LANE-1:0]  insts,
    output logic                  [`ISSUE_LANE-1:0]     insts_ready,

    // Retire pulses, lane 0 older
    output logic                  [`NUM_DE_INST-1:0]    rt_valid,
    output rvv_data_pkg::rt_result_t [`NUM_DE_INST-1:0] rt
);

    logic                   [`NUM_DE_INST-1:0] head_valid;
    rvv_inst_pkg::rvv_cmd_t [`NUM_DE_INST-1:0] head;

    logic                   [`NUM_DE_INST-1:0] uop_valid;
    rvv_inst_pkg::rvv_uop_t [`NUM_DE_INST-1:0] uop;

    rvv_cmd_queue u_cmd_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts       (insts),
        .insts_ready (insts_ready),
        .head_valid  (head_valid),
        .head        (head)
    );

    rvv_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head       (head),
        .uop_valid  (uop_valid),
        .uop        (uop)
    );

    rvv_vexec u_vexec (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop       (uop),
        .rt_valid  (rt_valid),
        .rt        (rt)
    );

endmodule

// File: tb/tb_rvv_backend.sv
`include "rvv_config.svh"

module tb_rvv_backend;

    // Test lengths that set the watchdog limit
    localparam int RESET_CYCLES   = 10;
    localparam int FRESH_NUM      = 32;
    localparam int PAIR_NUM       = 24;
    localparam int RAND_CYCLES    = 200;
    localparam int FLOOD_CYCLES   = 12;
    localparam int STIM_CYCLES    = RESET_CYCLES + FRESH_NUM * 4 + PAIR_NUM * 2
                                    + RAND_CYCLES + FLOOD_CYCLES;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 50;

    // One expected retire in acceptance order
    typedef struct packed {
        rvv_inst_pkg::vreg_idx_t vd;
        rvv_data_pkg::vreg_t     data;
        logic                    fixed_lat;
        int                      acc_cycle;
    } exp_t;

    logic                                        clk;
    logic                                        rst_n;
    logic                     [`ISSUE_LANE-1:0]  insts_valid;
    rvv_inst_pkg::rvv_cmd_t   [`ISSUE_LANE-1:0]  insts;
    logic                     [`ISSUE_LANE-1:0]  insts_ready;
    logic                     [`NUM_DE_INST-1:0] rt_valid;
    rvv_data_pkg::rt_result_t [`NUM_DE_INST-1:0] rt;

    logic [31:0] lfsr;
    logic [31:0] next_pc;
    int          watchdog;

    // Reference state updated at acceptance
    rvv_data_pkg::vreg_t ref_vrf [`NUM_VREG];
    exp_t                exp_q [$];
    int                  ref_occ;
    int                  edge_cnt;

    // Copies taken at each edge for the assertions
    exp_t [`NUM_DE_INST-1:0] chk_front;
    int                      chk_cnt;
    logic [`ISSUE_LANE-1:0]  chk_ready;
    int                      chk_edge;

    rvv_backend rvv_backend_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts       (insts),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid),
        .rt          (rt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic int pick(input int m);
        return int'(take_bits(8)) % m;
    endfunction

    function automatic rvv_inst_pkg::rvv_cmd_t rand_cmd();
        rvv_inst_pkg::rvv_cmd_t c;
        logic [1:0]             op_bits;
        op_bits    = 2'(take_bits(2));
        c.inst_pc  = next_pc;
        c.op       = rvv_inst_pkg::vop_e'(op_bits);
        c.vd       = rvv_inst_pkg::vreg_idx_t'(take_bits(5));
        c.vs1      = rvv_inst_pkg::vreg_idx_t'(take_bits(5));
        c.vs2      = rvv_inst_pkg::vreg_idx_t'(take_bits(5));
        c.rs1_data = take_bits(32);
        next_pc    = next_pc + 32'd4;
        return c;
    endfunction

    // Element rules of the four ops on the reference registers
    function automatic rvv_data_pkg::vreg_t ref_exec(input rvv_inst_pkg::rvv_cmd_t c);
        rvv_data_pkg::vreg_t r;
        int a;
        int b;
        int x;
        int v;
        x = int'(c.rs1_data % 32'd256);
        for (int e = 0; e < `VELEM_NUM; e++) begin
            a = int'(ref_vrf[c.vs1][e*`SEW +: `SEW]);
            b = int'(ref_vrf[c.vs2][e*`SEW +: `SEW]);
            case (c.op)
                rvv_inst_pkg::VOP_ADD_VV: v = a + b;
                rvv_inst_pkg::VOP_ADD_VX: v = b + x;
                rvv_inst_pkg::VOP_SUB_VV: v = b - a;
                default:                  v = x - b;
            endcase
            // Differences can be negative before the wrap
            r[e*`SEW +: `SEW] = `SEW'((v + 512) % 256);
        end
        return r;
    endfunction

    function automatic logic [`ISSUE_LANE-1:0] ready_mask(input int occ);
        logic [`ISSUE_LANE-1:0] m;
        for (int k = 0; k < `ISSUE_LANE; k++) begin
            m[k] = (`CQ_DEPTH - occ) >= k + 1;
        end
        return m;
    endfunction

    task automatic issue(input rvv_inst_pkg::rvv_cmd_t [`ISSUE_LANE-1:0] cmds, input int n);
        @(posedge clk);
        insts       <= cmds;
        insts_valid <= `ISSUE_LANE'((1 << n) - 1);
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            insts_valid <= '0;
        end
    endtask

    // Reference model of the whole backend
    always @(posedge clk or negedge rst_n) begin
        exp_t                   e;
        int                     n_acc;
        int                     n_pop;
        logic [`ISSUE_LANE-1:0] rdy;
        if (!rst_n) begin
            for (int k = 0; k < `NUM_VREG; k++) begin
                ref_vrf[k] = {`VELEM_NUM{`SEW'(k)}};
            end
            exp_q.delete();
            ref_occ   = 0;
            edge_cnt  = 0;
            chk_front <= '0;
            chk_cnt   <= 0;
            chk_ready <= ready_mask(0);
            chk_edge  <= 0;
        end else begin
            edge_cnt = edge_cnt + 1;
            // Retires seen at this edge were checked against the old front
            for (int j = 0; j < `NUM_DE_INST; j++) begin
                if (rt_valid[j] && exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                end
            end
            // Lanes the queue takes given the modeled occupancy
            rdy   = ready_mask(ref_occ);
            n_acc = 0;
            for (int k = 0; k < `ISSUE_LANE; k++) begin
                if (insts_valid[k] && rdy[k]) begin
                    e.vd        = insts[k].vd;
                    e.data      = ref_exec(insts[k]);
                    // From an empty queue the first pair pops together
                    e.fixed_lat = (ref_occ == 0) && (n_acc < `NUM_DE_INST);
                    e.acc_cycle = edge_cnt;
                    ref_vrf[insts[k].vd] = e.data;
                    exp_q.push_back(e);
                    n_acc++;
                end
            end
            n_pop   = (ref_occ < `NUM_DE_INST) ? ref_occ : `NUM_DE_INST;
            ref_occ = ref_occ + n_acc - n_pop;
            for (int j = 0; j < `NUM_DE_INST; j++) begin
                if (j < exp_q.size()) begin
                    chk_front[j] <= exp_q[j];
                end else begin
                    chk_front[j] <= '0;
                end
            end
            chk_cnt   <= exp_q.size();
            chk_ready <= ready_mask(ref_occ);
            chk_edge  <= edge_cnt;
        end
    end

    a_ready_therm: assert property (@(posedge clk) disable iff (!rst_n)
        insts_ready == chk_ready)
    else abort_run($sformatf("Error at %0t: insts_ready is %b, expected %b",
                             $time, $sampled(insts_ready), $sampled(chk_ready)));

    a_rt_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid[1] |-> rt_valid[0])
    else abort_run($sformatf("Error at %0t: lane 1 retired without lane 0", $time));

    for (genvar j = 0; j < `NUM_DE_INST; j++) begin : g_rt_chk
        // Lane j carries the j-th oldest pending instruction
        a_rt_data: assert property (@(posedge clk) disable iff (!rst_n)
            rt_valid[j] |-> chk_cnt > j && rt[j].vd == chk_front[j].vd
                            && rt[j].data == chk_front[j].data)
        else abort_run($sformatf("Error at %0t: lane %0d retired v%0d %h, expected v%0d %h",
                                 $time, j, $sampled(rt[j].vd), $sampled(rt[j].data),
                                 $sampled(chk_front[j].vd), $sampled(chk_front[j].data)));

        a_rt_latency: assert property (@(posedge clk) disable iff (!rst_n)
            rt_valid[j] && chk_front[j].fixed_lat |-> chk_edge - chk_front[j].acc_cycle == 2)
        else abort_run($sformatf("Error at %0t: lane %0d retired %0d cycles after accept",
                                 $time, j, $sampled(chk_edge - chk_front[j].acc_cycle)));
    end

    always @(posedge clk) begin
        watchdog <= watchdog + 1;
        if (watchdog >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Run timed out after %0d cycles", watchdog));
        end
    end

    initial begin
        rvv_inst_pkg::rvv_cmd_t [`ISSUE_LANE-1:0] cmds;
        int                                       n;
        lfsr        = 32'd20220;
        next_pc     = 32'h8000_0000;
        watchdog    = 0;
        rst_n       = 1'b0;
        insts_valid = '0;
        insts       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Fresh destinations with sources still at the reset image
        for (int i = 0; i < FRESH_NUM; i++) begin
            cmds        = '0;
            cmds[0]     = rand_cmd();
            cmds[0].op  = rvv_inst_pkg::VOP_ADD_VV;
            cmds[0].vd  = rvv_inst_pkg::vreg_idx_t'(i);
            cmds[0].vs1 = rvv_inst_pkg::vreg_idx_t'(i + pick(FRESH_NUM - i));
            cmds[0].vs2 = rvv_inst_pkg::vreg_idx_t'(i + pick(FRESH_NUM - i));
            issue(cmds, 1);
            idle(pick(4));
        end

        // Pairs where lane 1 reads lane 0's destination
        for (int i = 0; i < PAIR_NUM; i++) begin
            cmds    = '0;
            cmds[0] = rand_cmd();
            cmds[1] = rand_cmd();
            n       = pick(3);
            if (n != 1) begin
                cmds[1].vs1 = cmds[0].vd;
            end
            if (n != 0) begin
                cmds[1].vs2 = cmds[0].vd;
            end
            issue(cmds, 2);
            idle(pick(2));
        end

        // Random lane counts where zero lanes gives an idle cycle
        for (int c = 0; c < RAND_CYCLES; c++) begin
            for (int k = 0; k < `ISSUE_LANE; k++) begin
                cmds[k] = rand_cmd();
            end
            issue(cmds, pick(`ISSUE_LANE + 1));
        end

        // All four lanes every cycle until the queue backs up
        for (int c = 0; c < FLOOD_CYCLES; c++) begin
            for (int k = 0; k < `ISSUE_LANE; k++) begin
                cmds[k] = rand_cmd();
            end
            issue(cmds, `ISSUE_LANE);
        end
        idle(1);

        while (chk_cnt != 0) begin
            @(posedge clk);
        end
        idle(5);

        if (insts_ready == '1) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("Queue not empty at the end of the run");
        end
    end

endmodule

// File: files.f
+incdir+design
design/rvv_data_pkg.sv
design/rvv_inst_pkg.sv
design/rvv_cmd_queue.sv
design/rvv_decode.sv
design/rvv_vexec.sv
design/rvv_backend.sv
tb/tb_rvv_backend.sv

// File: Makefile
# Verilator build and run of the vector backend testbench

VERILATOR ?= verilator
TOP       ?= tb_rvv_backend
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
